// ==== design/dc_ctrl_pkg.sv ====
package dc_ctrl_pkg;

  localparam int PADDR_W = 37; // physical line address
  localparam int REQ_W   = 5;
  localparam int NODE_W  = 5;

  typedef logic [REQ_W-1:0]  req_id_t;
  typedef logic [NODE_W-1:0] node_id_t;

  // node and request id as carried on the ring bus
  typedef struct packed {
    node_id_t node;
    req_id_t  req;
  } bus_tag_t;

  typedef struct packed {
    logic [PADDR_W-1:0] addr;
    req_id_t            req;
    logic               io;
    logic [4:0]         sz;
    logic [4:0]         bank0;
    logic [1:0]         low;
    logic               dupl;
    logic               want_excl;
  } rd_req_t;

  typedef struct packed {
    logic [PADDR_W-1:0] addr;
    req_id_t            req;
    logic               io;
    logic               dupl;
    logic               want_excl;
  } miss_req_t;

  typedef struct packed {
    logic [PADDR_W-1:0] addr;
    bus_tag_t           src_req;
    logic               mem_req;
    logic               io_req;
    logic               want_excl;
    logic               dupl;
    logic               code;
  } rbus_req_t;

  typedef struct packed {
    logic     used;
    logic     mem_reply;
    bus_tag_t dst_req;
  } rbus_reply_t;

  typedef enum logic {
    PORT_READ   = 1'b0,
    PORT_INSERT = 1'b1
  } port_kind_e;

  typedef struct packed {
    logic               valid;
    port_kind_e         kind;
    logic [PADDR_W-1:0] addr;
    req_id_t            req;
    logic               dupl;
    logic               want_excl;
  } cache_port_t;

endpackage

// ==== design/dc_req_fifo.sv ====
`timescale 1ns/1ps

module dc_req_fifo #(
  parameter type DATA_T     = logic [7:0],
  parameter int  DEPTH      = 20,
  parameter int  SKIP_LEVEL = 12
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  push,
  input  DATA_T push_data,
  input  logic  pop,
  output DATA_T head,
  output logic  not_empty,
  output logic  skip
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_POS = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] SKIP_CNT = CNT_W'(SKIP_LEVEL);

  DATA_T            mem [DEPTH];
  logic [PTR_W-1:0] wr_pos;
  logic [PTR_W-1:0] rd_pos;
  logic [CNT_W-1:0] count;

  assign head      = mem[rd_pos];
  assign not_empty = count != '0;
  assign skip      = count >= SKIP_CNT; // early warning to the load pipe

  always_ff @(posedge clk) begin
    if (push) mem[wr_pos] <= push_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_pos <= '0;
      rd_pos <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_pos <= (wr_pos == LAST_POS) ? '0 : wr_pos + 1'b1; // wraps, depth need not be 2^n
      end
      if (pop) begin
        rd_pos <= (rd_pos == LAST_POS) ? '0 : rd_pos + 1'b1;
      end
      // push and pop together leave count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// ==== design/dc_miss_tracker.sv ====
`timescale 1ns/1ps

module dc_miss_tracker
  import dc_ctrl_pkg::*;
#(
  parameter node_id_t NODE_ID = '0
) (
  input  logic        clk,
  input  logic        rst,
  input  miss_req_t   miss_head,
  input  logic        miss_valid,
  output logic        miss_pop,
  output logic        rbus_want,
  output rbus_req_t   rbus_req,
  input  logic        rbus_can,
  input  rbus_reply_t rbus_reply,
  output cache_port_t insert
);

  localparam int ENTRIES = 2 ** REQ_W;

  typedef struct packed {
    logic [PADDR_W-1:0] addr;
    logic               dupl;
  } pend_ent_t;

  pend_ent_t   pend_mem [ENTRIES];
  logic        init;
  req_id_t     init_cnt;
  logic        accept;
  rbus_reply_t reply_q;
  logic        reply_hit;
  pend_ent_t   reply_ent;

  // table clear, one entry per cycle after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      init     <= 1'b1;
      init_cnt <= '0;
    end else if (init) begin
      init_cnt <= init_cnt + 1'b1;
      if (init_cnt == req_id_t'(ENTRIES - 1)) init <= 1'b0;
    end
  end

  assign rbus_want = miss_valid && !init;
  assign accept    = rbus_want && rbus_can;
  assign miss_pop  = accept;

  // head of miss queue goes straight out, stable until accepted
  always_comb begin
    rbus_req.addr         = miss_head.addr;
    rbus_req.src_req.node = NODE_ID;
    rbus_req.src_req.req  = miss_head.req;
    rbus_req.mem_req      = !miss_head.io;
    rbus_req.io_req       = miss_head.io;
    rbus_req.want_excl    = miss_head.want_excl;
    rbus_req.dupl         = miss_head.dupl;
    rbus_req.code         = miss_head.req[REQ_W-1] && !miss_head.req[REQ_W-2]; // code ids are 10xxx
  end

  always_ff @(posedge clk) begin
    if (init) begin
      pend_mem[init_cnt] <= '0;
    end else if (accept) begin
      pend_mem[miss_head.req] <= '{addr: miss_head.addr, dupl: miss_head.dupl};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) reply_q <= '0;
    else     reply_q <= rbus_reply;
  end

  assign reply_hit = reply_q.used && reply_q.mem_reply && reply_q.dst_req.node == NODE_ID;
  assign reply_ent = pend_mem[reply_q.dst_req.req];

  always_comb begin
    insert.valid     = reply_hit;
    insert.kind      = PORT_INSERT;
    insert.addr      = reply_ent.addr;
    insert.req       = reply_q.dst_req.req;
    insert.dupl      = reply_ent.dupl;
    insert.want_excl = 1'b0; // line fill, never exclusive here
  end

endmodule

// ==== design/dc_port_arbiter.sv ====
`timescale 1ns/1ps

module dc_port_arbiter
  import dc_ctrl_pkg::*;
(
  input  cache_port_t insert,
  input  rd_req_t     rd_head,
  input  logic        rd_valid,
  output logic        rd_pop,
  output cache_port_t cache_port
);

  cache_port_t rd_op;
  logic        rd_grant;

  // read head as a port op
  always_comb begin
    rd_op.valid     = rd_valid;
    rd_op.kind      = PORT_READ;
    rd_op.addr      = rd_head.addr;
    rd_op.req       = rd_head.req;
    rd_op.dupl      = rd_head.dupl;
    rd_op.want_excl = rd_head.want_excl;
  end

  // insert always wins the port
  assign rd_grant = rd_valid && !insert.valid;
  assign rd_pop   = rd_grant; // only when actually presented

  always_comb begin
    if (insert.valid) begin
      cache_port = insert;
    end else begin
      cache_port = rd_op; // valid only with a queued read
    end
  end

endmodule

// ==== design/dc_ctrl_top.sv ====
`timescale 1ns/1ps

module dc_ctrl_top
  import dc_ctrl_pkg::*;
#(
  parameter node_id_t NODE_ID    = 0,
  parameter int       RD_DEPTH   = 20,
  parameter int       SKIP_LEVEL = 12,
  parameter int       MISS_DEPTH = 28
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        rd_en,
  input  rd_req_t     rd_req,
  input  logic        miss_en,
  input  miss_req_t   miss_req,
  input  logic        rbus_can,
  input  rbus_reply_t rbus_reply,
  output logic        do_skip,
  output logic        rbus_want,
  output rbus_req_t   rbus_req,
  output cache_port_t cache_port
);

  rd_req_t     rd_head;
  logic        rd_valid;
  logic        rd_pop;
  miss_req_t   miss_head;
  logic        miss_valid;
  logic        miss_pop;
  cache_port_t insert;

  dc_req_fifo #(
    .DATA_T     (rd_req_t),
    .DEPTH      (RD_DEPTH),
    .SKIP_LEVEL (SKIP_LEVEL)
  ) u_rd_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (rd_en),
    .push_data (rd_req),
    .pop       (rd_pop),
    .head      (rd_head),
    .not_empty (rd_valid),
    .skip      (do_skip)
  );

  // miss queue has no skip output in use
  dc_req_fifo #(
    .DATA_T     (miss_req_t),
    .DEPTH      (MISS_DEPTH),
    .SKIP_LEVEL (MISS_DEPTH)
  ) u_miss_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (miss_en),
    .push_data (miss_req),
    .pop       (miss_pop),
    .head      (miss_head),
    .not_empty (miss_valid),
    .skip      ()
  );

  dc_miss_tracker #(
    .NODE_ID (NODE_ID)
  ) u_miss_tracker (
    .clk        (clk),
    .rst        (rst),
    .miss_head  (miss_head),
    .miss_valid (miss_valid),
    .miss_pop   (miss_pop),
    .rbus_want  (rbus_want),
    .rbus_req   (rbus_req),
    .rbus_can   (rbus_can),
    .rbus_reply (rbus_reply),
    .insert     (insert)
  );

  dc_port_arbiter u_port_arbiter (
    .insert     (insert),
    .rd_head    (rd_head),
    .rd_valid   (rd_valid),
    .rd_pop     (rd_pop),
    .cache_port (cache_port)
  );

endmodule

// ==== dv/dc_ctrl_assertions.sv ====
`timescale 1ns/1ps

module dc_ctrl_assertions
  import dc_ctrl_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input logic        rd_en,
  input logic        miss_en,
  input logic        rbus_can,
  input logic        do_skip,
  input logic        rbus_want,
  input rd_req_t     rd_req,
  input miss_req_t   miss_req,
  input rbus_reply_t rbus_reply,
  input rbus_req_t   rbus_req,
  input cache_port_t cache_port
);

  int               err_cnt = 0;
  int               post_rst = 32;  // edges since rst fell, saturating
  int               rd_cnt;         // reads pushed minus reads presented
  rd_req_t          rd_q [32];      // reads in push order
  logic [4:0]       rd_wr;
  logic [4:0]       rd_rd;
  miss_req_t        miss_q [64];    // misses in push order
  logic [5:0]       miss_wr;
  logic [5:0]       miss_rd;
  logic [PADDR_W:0] acc_tab [32];   // {dupl, addr} accepted per request id
  logic             ins_exp;
  logic [PADDR_W:0] ins_ref;
  req_id_t          ins_req;
  logic             rd_pres;
  logic             accept;

  assign rd_pres = cache_port.valid && cache_port.kind == PORT_READ;
  assign accept  = rbus_want && rbus_can;

  always_ff @(posedge clk) begin
    if (rd_en) rd_q[rd_wr] <= rd_req;
    if (miss_en) miss_q[miss_wr] <= miss_req;
    if (accept) acc_tab[rbus_req.src_req.req] <= {rbus_req.dupl, rbus_req.addr};
    ins_ref <= acc_tab[rbus_reply.dst_req.req];
    ins_req <= rbus_reply.dst_req.req;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      post_rst <= 0;
      rd_cnt   <= 0;
      rd_wr    <= '0;
      rd_rd    <= '0;
      miss_wr  <= '0;
      miss_rd  <= '0;
      ins_exp  <= 1'b0;
    end else begin
      post_rst <= (post_rst < 40) ? post_rst + 1 : post_rst;
      rd_cnt   <= rd_cnt + int'(rd_en) - int'(rd_pres);
      rd_wr    <= rd_wr + 5'(rd_en);
      rd_rd    <= rd_rd + 5'(rd_pres);
      miss_wr  <= miss_wr + 6'(miss_en);
      miss_rd  <= miss_rd + 6'(accept);
      ins_exp  <= rbus_reply.used && rbus_reply.mem_reply && rbus_reply.dst_req.node == '0;
    end
  end

  // quiet in reset, no bus request while the table clears
  a_reset: assert property (@(posedge clk)
    post_rst < 32 |-> !rbus_want && (post_rst != 0 || !cache_port.valid)) else begin
      $error("bus request or cache port active during reset or table clear");
      err_cnt++;
    end

  // bus request as soon as a miss waits and the clear is done
  a_want: assert property (@(posedge clk) disable iff (rst)
    rbus_want == (post_rst >= 32 && miss_wr != miss_rd)) else begin
      $error("Error rbus_want %h expected %h", rbus_want, post_rst >= 32 && miss_wr != miss_rd);
      err_cnt++;
    end

  // reads leave in push order whenever no insert holds the port
  a_rd_order: assert property (@(posedge clk) disable iff (rst)
    rd_pres == (rd_cnt != 0 && !ins_exp) &&
      (!rd_pres || (cache_port.addr == rd_q[rd_rd].addr &&
      cache_port.req == rd_q[rd_rd].req && cache_port.dupl == rd_q[rd_rd].dupl &&
      cache_port.want_excl == rd_q[rd_rd].want_excl))) else begin
      $error("Error cache_port %h expected read %h", cache_port, rd_q[rd_rd]);
      err_cnt++;
    end

  a_levels: assert property (@(posedge clk) disable iff (rst)
    do_skip == (rd_cnt >= 12) && !(rd_en && rd_cnt >= 20) &&
      !(miss_en && 6'(miss_wr - miss_rd) >= 6'd28)) else begin
      $error("Error do_skip %h read level %h miss level %h", do_skip, rd_cnt,
        6'(miss_wr - miss_rd));
      err_cnt++;
    end

  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    rbus_want && !rbus_can |=> rbus_want && $stable(rbus_req)) else begin
      $error("Error rbus_req %h changed from %h while stalled", rbus_req, $past(rbus_req));
      err_cnt++;
    end

  // node 0, code ids are 10xxx
  a_miss_order: assert property (@(posedge clk) disable iff (rst)
    accept |-> rbus_req.addr == miss_q[miss_rd].addr && rbus_req.src_req.node == '0 &&
      rbus_req.src_req.req == miss_q[miss_rd].req && rbus_req.dupl == miss_q[miss_rd].dupl &&
      rbus_req.want_excl == miss_q[miss_rd].want_excl &&
      rbus_req.io_req == miss_q[miss_rd].io && rbus_req.mem_req == !miss_q[miss_rd].io &&
      rbus_req.code == (rbus_req.src_req.req[REQ_W-1:REQ_W-2] == 2'b10)) else begin
      $error("Error rbus_req %h expected miss %h", rbus_req, miss_q[miss_rd]);
      err_cnt++;
    end

  a_insert: assert property (@(posedge clk) disable iff (rst)
    (cache_port.valid && cache_port.kind == PORT_INSERT) == ins_exp &&
      (!ins_exp || ({cache_port.dupl, cache_port.addr} == ins_ref &&
      cache_port.req == ins_req))) else begin
      $error("Error cache_port %h expected insert %h of %h", cache_port, ins_exp, ins_ref);
      err_cnt++;
    end

endmodule

bind dc_ctrl_top dc_ctrl_assertions u_chk (.*);

// ==== dv/dc_ctrl_tb.sv ====
`timescale 1ns/1ps

module dc_ctrl_tb
  import dc_ctrl_pkg::*;
();

  logic               clk = 1'b0;
  logic               rst;
  logic               rd_en;
  rd_req_t            rd_req;
  logic               miss_en;
  miss_req_t          miss_req;
  logic               rbus_can;
  rbus_reply_t        rbus_reply;
  logic               do_skip;
  logic               rbus_want;
  rbus_req_t          rbus_req;
  cache_port_t        cache_port;
  logic [PADDR_W-1:0] rd_addr = PADDR_W'(256); // reads go out at consecutive addresses
  logic               stall_bus = 1'b0;
  logic               timed_out = 1'b0;
  req_id_t            miss_ids [$];
  int                 pass_cnt = 0;
  int                 fail_cnt = 0;

  dc_ctrl_top i_dc_ctrl_top (.*);

  always #5 clk = ~clk;

  task automatic next_cycle();
    @(negedge clk);
    rd_en      = 1'b0;
    miss_en    = 1'b0;
    rbus_reply = '0;
    rbus_can   = stall_bus ? 1'($urandom) : 1'b1;
  endtask

  task automatic push_read();
    rd_req.addr      = rd_addr;
    rd_req.req       = req_id_t'($urandom);
    rd_req.sz        = 5'($urandom);
    rd_req.bank0     = 5'($urandom);
    rd_req.low       = 2'($urandom);
    rd_req.dupl      = 1'($urandom);
    rd_req.want_excl = 1'($urandom);
    rd_en            = 1'b1;
    rd_addr          = rd_addr + PADDR_W'(1);
  endtask

  task automatic push_miss();
    miss_req.addr      = PADDR_W'({$urandom, $urandom});
    miss_req.req       = req_id_t'($urandom);
    miss_req.io        = 1'($urandom);
    miss_req.dupl      = 1'($urandom);
    miss_req.want_excl = 1'($urandom);
    miss_en            = 1'b1;
    miss_ids.push_back(miss_req.req);
  endtask

  // reply for an id already sent out, own node or a foreign one
  task automatic send_reply(input logic own);
    rbus_reply.used         = 1'b1;
    rbus_reply.mem_reply    = 1'b1;
    rbus_reply.dst_req.node = own ? node_id_t'(0) : node_id_t'(1 + $urandom_range(0, 30));
    rbus_reply.dst_req.req  = miss_ids[$urandom_range(0, miss_ids.size() - 1)];
  endtask

  function automatic logic cond_met(input string what);
    if (what == "bus request") return rbus_want;
    if (what == "bus idle") return !rbus_want;
    return !cache_port.valid; // port idle
  endfunction

  task automatic wait_for(input string what, input int limit);
    int n;
    n = 0;
    do begin
      next_cycle();
      n++;
    end while (!cond_met(what) && n < limit);
    if (!cond_met(what)) begin
      $display("timeout after %0d cycles waiting for %s", limit, what);
      timed_out = 1'b1;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    int errs;
    errs = i_dc_ctrl_top.u_chk.err_cnt - errs_before;
    if (errs == 0 && !timed_out) begin
      pass_cnt++;
      $display("test %s passed", name);
    end else begin
      fail_cnt++;
      $display("test %s failed with %0d assertion errors", name, errs);
    end
  endtask

  initial begin
    int errs0;
    int n;
    void'($urandom(93187));
    rst        = 1'b1;
    rd_en      = 1'b0;
    miss_en    = 1'b0;
    miss_req   = '0;
    rbus_can   = 1'b1;
    rbus_reply = '0;
    rd_req     = '0;
    repeat (10) next_cycle();
    rst = 1'b0;

    errs0     = i_dc_ctrl_top.u_chk.err_cnt;
    stall_bus = 1'b1;
    repeat (4) begin
      next_cycle();
      push_miss();
    end
    wait_for("bus request", 60);
    wait_for("bus idle", 100);
    end_test("after_reset", errs0);

    errs0 = i_dc_ctrl_top.u_chk.err_cnt;
    repeat (40) begin
      next_cycle();
      if ($urandom_range(0, 3) != 0) push_read();
    end
    wait_for("port idle", 40);
    end_test("read_order", errs0);

    errs0 = i_dc_ctrl_top.u_chk.err_cnt;
    repeat (24) begin
      next_cycle();
      if ($urandom_range(0, 1) == 1) push_miss();
    end
    wait_for("bus idle", 200);
    stall_bus = 1'b0;
    end_test("bus_issue", errs0);

    errs0 = i_dc_ctrl_top.u_chk.err_cnt;
    repeat (60) begin
      next_cycle();
      if (!do_skip && $urandom_range(0, 1) == 1) push_read();
      if ($urandom_range(0, 1) == 1) send_reply($urandom_range(0, 3) != 0);
    end
    wait_for("port idle", 40);
    end_test("reply_insert", errs0);

    // inserts hold the port so the read queue fills up
    errs0 = i_dc_ctrl_top.u_chk.err_cnt;
    n     = 0;
    next_cycle();
    while (!do_skip && n < 40) begin
      push_read();
      send_reply(1'b1);
      next_cycle();
      n++;
    end
    if (!do_skip) begin
      $display("timeout, do_skip never rose during the read burst");
      timed_out = 1'b1;
    end
    wait_for("port idle", 60);
    end_test("skip_flag", errs0);

    $display("%0d tests passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && !timed_out && i_dc_ctrl_top.u_chk.err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
design/dc_ctrl_pkg.sv
design/dc_req_fifo.sv
design/dc_miss_tracker.sv
design/dc_port_arbiter.sv
design/dc_ctrl_top.sv
dv/dc_ctrl_assertions.sv
dv/dc_ctrl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dc_ctrl_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_FLAGS ?= +verilator+error+limit+1000

SRCS := $(shell cat filelist.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) filelist.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f filelist.f

run: $(BIN)
	$(BIN) $(SIM_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^ALL TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
